// ==== Bender.yml ====
package:
  name: spmmio

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/spmmio_pkg.sv
      - common/spmmio_bus_if.sv
      - misc/spmmio_misc.sv
      - keyboard/spmmio_keyboard.sv
      - uart/spmmio_uart.sv
      - rtl/spmmio.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/spmmio_checker.sv
      - tests/tb_spmmio.sv

// ==== common/spmmio_bus_if.sv ====
`timescale 1ns/10ps

// Register port between the decoder and one unit.
interface spmmio_bus_if;

   spmmio_pkg::reg_adr_t adr;
   logic                 cs;  // Access in every cycle where high.
   spmmio_pkg::sel_t     sel;
   logic                 we;
   spmmio_pkg::word_t    d;
   spmmio_pkg::word_t    q;   // Combinational read data.

   modport host (
      output adr,
      output cs,
      output sel,
      output we,
      output d,
      input  q
   );

   modport unit (
      input  adr,
      input  cs,
      input  sel,
      input  we,
      input  d,
      output q
   );

endinterface

// ==== common/spmmio_params.svh ====
`ifndef SPMMIO_PARAMS_SVH
`define SPMMIO_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Unit numbers, decoded from address bits 0 to 7
`define SPMMIO_UNIT_MISC   8'd0
`define SPMMIO_UNIT_UART   8'd2
`define SPMMIO_UNIT_KBD    8'd4

// ~~~~~~~~~~~~~~~~~~~~
// Register offsets, address bits 18 to 21
`define SPMMIO_MISC_LED    4'd0
`define SPMMIO_MISC_SWRST  4'd1
`define SPMMIO_MISC_RGB1   4'd2
`define SPMMIO_MISC_RGB2   4'd3
`define SPMMIO_MISC_RGB3   4'd4
`define SPMMIO_MISC_RGB4   4'd5
`define SPMMIO_MISC_DRIVE  4'd6

`define SPMMIO_KBD_DATA    4'd0
`define SPMMIO_KBD_CTRL    4'd1

`define SPMMIO_UART_TX     4'd0
`define SPMMIO_UART_STAT   4'd1
`define SPMMIO_UART_RX     4'd2

`define SPMMIO_UART_DIV    8 // Clocks per bit.

`endif

// ==== common/spmmio_pkg.sv ====
`include "spmmio_params.svh"

package spmmio_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // Bus types, bit 0 is the most significant bit
   typedef logic [0:31] word_t;
   typedef logic [0:23] adr_t;     // Byte address, bit 21 is the last word bit.
   typedef logic [0:3]  sel_t;     // Lane 0 covers data bits 0 to 7.
   typedef logic [0:3]  reg_adr_t; // Address bits 18 to 21.

   // ~~~~~~~~~~~~~~~~~~~~
   // Register payloads
   typedef logic [0:23] rgb_t;

   typedef enum logic [0:7] {
      UNIT_MISC = `SPMMIO_UNIT_MISC,
      UNIT_UART = `SPMMIO_UNIT_UART,
      UNIT_KBD  = `SPMMIO_UNIT_KBD
   } unit_e;

   // Shared by the transmitter and the receiver.
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      START = 2'd1,
      DATA  = 2'd2,
      STOP  = 2'd3
   } uart_state_e;

endpackage

// ==== keyboard/spmmio_keyboard.sv ====
`timescale 1ns/10ps
`include "spmmio_params.svh"

module spmmio_keyboard (
   input  logic       clk,
   input  logic       rst_n_i,
   spmmio_bus_if.unit bus,
   input  logic       keypress_i,
   input  logic [0:6] keycode_i,
   input  logic [0:3] shift_state_i,
   output logic       keyboard_block_o
);

   logic       data_rd;
   logic       ctrl_wr;
   logic       valid_q;
   logic       overrun_q;
   logic       block_q;
   logic [0:6] keycode_q;
   logic [0:3] shift_q;

   assign data_rd = bus.cs && !bus.we && bus.adr == `SPMMIO_KBD_DATA;
   assign ctrl_wr = bus.cs && bus.we && bus.adr == `SPMMIO_KBD_CTRL && bus.sel[3];

   // ~~~~~~~~~~~~~~~~~~~~
   // Key holding register
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q   <= 1'b0;
         overrun_q <= 1'b0;
      end else if (keypress_i) begin
         valid_q   <= 1'b1;
         overrun_q <= valid_q && !data_rd; // Unread entry is lost.
      end else if (data_rd) begin
         valid_q   <= 1'b0;
         overrun_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (keypress_i) begin
         keycode_q <= keycode_i;
         shift_q   <= shift_state_i;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Control
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         block_q <= 1'b0;
      end else if (ctrl_wr) begin
         block_q <= bus.d[31];
      end
   end

   always_comb begin
      bus.q = '0;
      case (bus.adr)
         `SPMMIO_KBD_DATA: begin
            bus.q[0]     = valid_q;
            bus.q[1]     = overrun_q;
            bus.q[21:24] = shift_q;
            bus.q[25:31] = keycode_q;
         end
         `SPMMIO_KBD_CTRL: bus.q[31] = block_q;
         default: ;
      endcase
   end

   assign keyboard_block_o = block_q;

endmodule

// ==== misc/spmmio_misc.sv ====
`timescale 1ns/10ps
`include "spmmio_params.svh"

module spmmio_misc (
   input  logic             clk,
   input  logic             rst_n_i,
   spmmio_bus_if.unit       bus,
   input  logic [1:3]       drive_activity_i,
   output logic             led_red_o,
   output logic             led_green_o,
   output logic [0:4]       sw_reset_o,
   output spmmio_pkg::rgb_t led1_rgb_o,
   output spmmio_pkg::rgb_t led2_rgb_o,
   output spmmio_pkg::rgb_t led3_rgb_o,
   output spmmio_pkg::rgb_t led4_rgb_o
);

   logic             wr;
   logic             led_red_q;
   logic             led_green_q;
   logic [0:4]       sw_reset_q;
   spmmio_pkg::rgb_t rgb_q [0:3];

   assign wr = bus.cs && bus.we;

   // ~~~~~~~~~~~~~~~~~~~~
   // Registers
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         led_red_q   <= 1'b0;
         led_green_q <= 1'b0;
         sw_reset_q  <= '0;
         for (int i = 0; i < 4; i++) begin
            rgb_q[i] <= '0;
         end
      end else begin
         sw_reset_q <= '0; // Pulse lasts one cycle.
         if (wr && bus.sel[3]) begin
            if (bus.adr == `SPMMIO_MISC_LED) begin
               led_red_q   <= bus.d[31];
               led_green_q <= bus.d[30];
            end
            if (bus.adr == `SPMMIO_MISC_SWRST) begin
               sw_reset_q <= bus.d[27:31];
            end
         end
         // RGB colour sits in lanes 1 to 3.
         for (int i = 0; i < 4; i++) begin
            if (wr && bus.adr == spmmio_pkg::reg_adr_t'(`SPMMIO_MISC_RGB1 + i)) begin
               for (int j = 1; j < 4; j++) begin
                  if (bus.sel[j]) begin
                     rgb_q[i][(j-1)*8 +: 8] <= bus.d[j*8 +: 8];
                  end
               end
            end
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Read data
   always_comb begin
      bus.q = '0;
      case (bus.adr)
         `SPMMIO_MISC_LED: begin
            bus.q[30] = led_green_q;
            bus.q[31] = led_red_q;
         end
         `SPMMIO_MISC_DRIVE: bus.q[29:31] = drive_activity_i;
         default: ;
      endcase
      for (int i = 0; i < 4; i++) begin
         if (bus.adr == spmmio_pkg::reg_adr_t'(`SPMMIO_MISC_RGB1 + i)) begin
            bus.q[8:31] = rgb_q[i];
         end
      end
   end

   assign led_red_o   = led_red_q;
   assign led_green_o = led_green_q;
   assign sw_reset_o  = sw_reset_q;
   assign led1_rgb_o  = rgb_q[0];
   assign led2_rgb_o  = rgb_q[1];
   assign led3_rgb_o  = rgb_q[2];
   assign led4_rgb_o  = rgb_q[3];

endmodule

// ==== rtl/spmmio.sv ====
`timescale 1ns/10ps

module spmmio (
   input  logic                 clk,
   input  logic                 rst_n_i,

   input  spmmio_pkg::adr_t     adr_i,
   input  logic                 stb_i,
   input  logic                 cyc_i,
   input  spmmio_pkg::sel_t     sel_i,
   input  logic                 we_i,
   input  spmmio_pkg::word_t    dat_i,
   output logic                 ack_o,
   output spmmio_pkg::word_t    dat_o,

   output logic                 led_red_o,
   output logic                 led_green_o,
   output logic [0:4]           sw_reset_o,
   output spmmio_pkg::rgb_t     led1_rgb_o,
   output spmmio_pkg::rgb_t     led2_rgb_o,
   output spmmio_pkg::rgb_t     led3_rgb_o,
   output spmmio_pkg::rgb_t     led4_rgb_o,
   input  logic [1:3]           drive_activity_i,

   input  logic                 keypress_i,
   input  logic [0:6]           keycode_i,
   input  logic [0:3]           shift_state_i,
   output logic                 keyboard_block_o,

   output logic                 uart_txd_o,
   input  logic                 uart_rxd_i
);

   localparam int NUM_BUS  = 3;
   localparam int BUS_MISC = 0;
   localparam int BUS_UART = 1;
   localparam int BUS_KBD  = 2;

   logic [0:NUM_BUS-1] unit_stb;

   spmmio_bus_if bus [NUM_BUS] ();

   // ~~~~~~~~~~~~~~~~~~~~
   // Unit decode and read mux
   assign ack_o = stb_i; // No unit inserts wait states.

   always_comb begin
      unit_stb = '0;
      dat_o    = '0; // Units 1, 3 and 5 and the rest read as zero.
      case (adr_i[0:7])
         spmmio_pkg::UNIT_MISC: begin
            unit_stb[BUS_MISC] = stb_i;
            dat_o              = bus[BUS_MISC].q;
         end
         spmmio_pkg::UNIT_UART: begin
            unit_stb[BUS_UART] = stb_i;
            dat_o              = bus[BUS_UART].q;
         end
         spmmio_pkg::UNIT_KBD: begin
            unit_stb[BUS_KBD] = stb_i;
            dat_o             = bus[BUS_KBD].q;
         end
         default: ;
      endcase
   end

   for (genvar g = 0; g < NUM_BUS; g++) begin : g_bus
      assign bus[g].adr = adr_i[18:21];
      assign bus[g].cs  = cyc_i && unit_stb[g];
      assign bus[g].sel = sel_i;
      assign bus[g].we  = we_i;
      assign bus[g].d   = dat_i;
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Units
   spmmio_misc u_misc (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .bus              (bus[BUS_MISC]),
      .drive_activity_i (drive_activity_i),
      .led_red_o        (led_red_o),
      .led_green_o      (led_green_o),
      .sw_reset_o       (sw_reset_o),
      .led1_rgb_o       (led1_rgb_o),
      .led2_rgb_o       (led2_rgb_o),
      .led3_rgb_o       (led3_rgb_o),
      .led4_rgb_o       (led4_rgb_o)
   );

   spmmio_uart u_uart (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .bus        (bus[BUS_UART]),
      .uart_rxd_i (uart_rxd_i),
      .uart_txd_o (uart_txd_o)
   );

   spmmio_keyboard u_keyboard (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .bus              (bus[BUS_KBD]),
      .keypress_i       (keypress_i),
      .keycode_i        (keycode_i),
      .shift_state_i    (shift_state_i),
      .keyboard_block_o (keyboard_block_o)
   );

endmodule

// ==== spmmio.f ====
+incdir+common
common/spmmio_pkg.sv
common/spmmio_bus_if.sv
misc/spmmio_misc.sv
keyboard/spmmio_keyboard.sv
uart/spmmio_uart.sv
rtl/spmmio.sv
tests/spmmio_checker.sv
tests/tb_spmmio.sv

// ==== tests/spmmio_checker.sv ====
`timescale 1ns/10ps

module spmmio_checker (
   input logic       clk,
   input logic       rst_n_i,
   input logic       stb_i,
   input logic       ack_i,
   input logic [0:4] sw_reset_i,
   input logic       txd_i
);

   int fail_count = 0;

   // ~~~~~~~~~~~~~~~~~~~~
   // Port rules
   ack_follows_stb: assert property (
      @(posedge clk) disable iff (!rst_n_i) ack_i == stb_i
   ) else begin
      $error("ack_o does not follow stb_i");
      fail_count++;
   end

   sw_reset_single_cycle: assert property (
      @(posedge clk) disable iff (!rst_n_i) (|sw_reset_i) |=> !(|sw_reset_i)
   ) else begin
      $error("sw_reset_o stayed nonzero for two cycles");
      fail_count++;
   end

   // Line must idle high once reset is released.
   txd_idle_after_reset: assert property (
      @(posedge clk) $rose(rst_n_i) |-> txd_i
   ) else begin
      $error("uart_txd_o not high after reset");
      fail_count++;
   end

endmodule

bind spmmio spmmio_checker u_checker (
   .clk        (clk),
   .rst_n_i    (rst_n_i),
   .stb_i      (stb_i),
   .ack_i      (ack_o),
   .sw_reset_i (sw_reset_o),
   .txd_i      (uart_txd_o)
);

// ==== tests/tb_spmmio.sv ====
`timescale 1ns/10ps
`include "spmmio_params.svh"

module tb_spmmio;

   localparam int MAX_CYCLES = 2000; // Four UART frames take most of the 600 cycles needed.

   logic                 clk;
   logic                 rst_n_i;
   spmmio_pkg::adr_t     adr_i;
   logic                 stb_i;
   logic                 cyc_i;
   spmmio_pkg::sel_t     sel_i;
   logic                 we_i;
   spmmio_pkg::word_t    dat_i;
   logic                 ack_o;
   spmmio_pkg::word_t    dat_o;
   logic                 led_red_o;
   logic                 led_green_o;
   logic [0:4]           sw_reset_o;
   spmmio_pkg::rgb_t     led_rgb_o [0:3];
   logic [2:0]           drive_activity_i;
   logic                 keypress_i;
   logic [0:6]           keycode_i;
   logic [0:3]           shift_state_i;
   logic                 keyboard_block_o;
   logic                 uart_txd_o;

   // Reference model state.
   logic                 led_red_m;
   logic                 led_green_m;
   spmmio_pkg::rgb_t     rgb_m [0:3];
   logic [2:0]           drive_m;
   logic                 kbd_valid_m;
   logic                 kbd_over_m;
   logic [0:6]           kbd_code_m;
   logic [0:3]           kbd_shift_m;
   logic                 block_m;
   logic                 rx_valid_m;
   logic [0:7]           rx_byte_m;

   logic                 cmp_en;
   spmmio_pkg::word_t    cmp_exp;
   logic [31:0]          lfsr_q;
   int                   cycles;
   int                   checks;
   int                   errors;

   spmmio u_spmmio (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .adr_i            (adr_i),
      .stb_i            (stb_i),
      .cyc_i            (cyc_i),
      .sel_i            (sel_i),
      .we_i             (we_i),
      .dat_i            (dat_i),
      .ack_o            (ack_o),
      .dat_o            (dat_o),
      .led_red_o        (led_red_o),
      .led_green_o      (led_green_o),
      .sw_reset_o       (sw_reset_o),
      .led1_rgb_o       (led_rgb_o[0]),
      .led2_rgb_o       (led_rgb_o[1]),
      .led3_rgb_o       (led_rgb_o[2]),
      .led4_rgb_o       (led_rgb_o[3]),
      .drive_activity_i (drive_activity_i),
      .keypress_i       (keypress_i),
      .keycode_i        (keycode_i),
      .shift_state_i    (shift_state_i),
      .keyboard_block_o (keyboard_block_o),
      .uart_txd_o       (uart_txd_o),
      .uart_rxd_i       (uart_txd_o)     // Loopback.
   );

   always #4 clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~
   // Helpers
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1.
   endfunction

   function logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         r      = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic spmmio_pkg::adr_t reg_addr(input logic [7:0] unit, input logic [3:0] r);
      return {unit, 10'b0, r, 2'b0};
   endfunction

   function automatic spmmio_pkg::word_t expected_read(input logic [7:0] unit,
                                                        input logic [3:0] r);
      spmmio_pkg::word_t q;
      q = '0;
      if (unit == `SPMMIO_UNIT_MISC) begin
         if (r == `SPMMIO_MISC_LED) q = {30'b0, led_green_m, led_red_m};
         if (r >= `SPMMIO_MISC_RGB1 && r <= `SPMMIO_MISC_RGB4) begin
            q = {8'b0, rgb_m[r - `SPMMIO_MISC_RGB1]};
         end
         if (r == `SPMMIO_MISC_DRIVE) q = {29'b0, drive_m};
      end else if (unit == `SPMMIO_UNIT_KBD) begin
         if (r == `SPMMIO_KBD_DATA) q = {kbd_valid_m, kbd_over_m, 19'b0, kbd_shift_m, kbd_code_m};
         if (r == `SPMMIO_KBD_CTRL) q = {31'b0, block_m};
      end else if (unit == `SPMMIO_UNIT_UART) begin
         if (r == `SPMMIO_UART_STAT) q = {30'b0, rx_valid_m, 1'b0}; // Tx idle when checked.
         if (r == `SPMMIO_UART_RX) q = {24'b0, rx_byte_m};
      end
      return q;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic bus_cycle(input logic we, input spmmio_pkg::adr_t adr,
                            input spmmio_pkg::sel_t sel, input spmmio_pkg::word_t wdata,
                            input logic chk, input spmmio_pkg::word_t exp,
                            output spmmio_pkg::word_t rdata);
      @(posedge clk);
      adr_i   <= adr;
      sel_i   <= sel;
      we_i    <= we;
      dat_i   <= wdata;
      stb_i   <= 1'b1;
      cyc_i   <= 1'b1;
      cmp_en  <= chk;
      cmp_exp <= exp;
      @(negedge clk);
      rdata = dat_o;
      @(posedge clk);
      stb_i  <= 1'b0;
      cyc_i  <= 1'b0;
      we_i   <= 1'b0;
      cmp_en <= 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] unit, input logic [3:0] r,
                            input spmmio_pkg::sel_t sel, input spmmio_pkg::word_t d);
      spmmio_pkg::word_t unused;
      spmmio_pkg::rgb_t  mask;
      bus_cycle(1'b1, reg_addr(unit, r), sel, d, 1'b0, '0, unused);
      mask = {{8{sel[1]}}, {8{sel[2]}}, {8{sel[3]}}};
      if (unit == `SPMMIO_UNIT_MISC) begin
         if (r == `SPMMIO_MISC_LED && sel[3]) begin
            led_red_m   = d[31];
            led_green_m = d[30];
         end
         if (r >= `SPMMIO_MISC_RGB1 && r <= `SPMMIO_MISC_RGB4) begin
            rgb_m[r - `SPMMIO_MISC_RGB1] = (rgb_m[r - `SPMMIO_MISC_RGB1] & ~mask)
                                           | (d[8:31] & mask);
         end
      end
      if (unit == `SPMMIO_UNIT_KBD && r == `SPMMIO_KBD_CTRL && sel[3]) block_m = d[31];
   endtask

   task automatic read_check(input logic [7:0] unit, input logic [3:0] r);
      spmmio_pkg::word_t got;
      bus_cycle(1'b0, reg_addr(unit, r), 4'hf, '0, 1'b1, expected_read(unit, r), got);
      if (unit == `SPMMIO_UNIT_KBD && r == `SPMMIO_KBD_DATA) begin
         kbd_valid_m = 1'b0;
         kbd_over_m  = 1'b0;
      end
      if (unit == `SPMMIO_UNIT_UART && r == `SPMMIO_UART_RX) rx_valid_m = 1'b0;
   endtask

   task automatic press_key(input logic [0:6] code, input logic [0:3] shift);
      @(posedge clk);
      keypress_i    <= 1'b1;
      keycode_i     <= code;
      shift_state_i <= shift;
      @(posedge clk);
      keypress_i <= 1'b0;
      kbd_over_m  = kbd_valid_m; // Unread entry overwritten.
      kbd_valid_m = 1'b1;
      kbd_code_m  = code;
      kbd_shift_m = shift;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // Compare and timeout
   always @(negedge clk) begin
      if (cmp_en) begin
         check_value("dat_o", dat_o, cmp_exp);
         check_value("ack_o", ack_o, 32'd1);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout, tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

   initial begin
      spmmio_pkg::word_t got;
      logic [7:0]        b;
      logic [4:0]        v;
      logic [2:0]        drv;
      int                idx;
      clk = 1'b0;
      rst_n_i = 1'b0;
      adr_i = '0;
      stb_i = 1'b0;
      cyc_i = 1'b0;
      sel_i = '0;
      we_i = 1'b0;
      dat_i = '0;
      drive_activity_i = '0;
      keypress_i = 1'b0;
      keycode_i = '0;
      shift_state_i = '0;
      cmp_en = 1'b0;
      cmp_exp = '0;
      lfsr_q = 32'd78966;
      cycles = 0;
      checks = 0;
      errors = 0;
      led_red_m = 1'b0;
      led_green_m = 1'b0;
      rgb_m = '{default: '0};
      drive_m = '0;
      kbd_valid_m = 1'b0;
      kbd_over_m = 1'b0;
      block_m = 1'b0;
      rx_valid_m = 1'b0;
      rx_byte_m = '0;
      repeat (5) @(posedge clk);
      rst_n_i <= 1'b1;
      @(negedge clk);
      check_value("led_red_o", led_red_o, 0);
      check_value("led_green_o", led_green_o, 0);
      check_value("sw_reset_o", sw_reset_o, 0);
      for (int i = 0; i < 4; i++) check_value("led_rgb_o", led_rgb_o[i], 0);
      check_value("keyboard_block_o", keyboard_block_o, 0);
      check_value("uart_txd_o", uart_txd_o, 1);

      // ~~~~~~~~~~~~~~~~~~~~
      // Misc registers
      for (int i = 0; i < 16; i++) begin
         idx = random_bits(3);
         if (idx > 3) write_reg(`SPMMIO_UNIT_MISC, `SPMMIO_MISC_LED, random_bits(4),
                                random_bits(32));
         else write_reg(`SPMMIO_UNIT_MISC, `SPMMIO_MISC_RGB1 + idx, random_bits(4),
                        random_bits(32));
      end
      @(negedge clk);
      check_value("led_red_o", led_red_o, led_red_m);
      check_value("led_green_o", led_green_o, led_green_m);
      for (int i = 0; i < 4; i++) check_value("led_rgb_o", led_rgb_o[i], rgb_m[i]);
      for (int r = 0; r < 8; r++) read_check(`SPMMIO_UNIT_MISC, r);
      drv = random_bits(3);
      @(posedge clk);
      drive_activity_i <= drv;
      drive_m = drv;
      read_check(`SPMMIO_UNIT_MISC, `SPMMIO_MISC_DRIVE);

      // Pulse shows one cycle after the write edge.
      v = random_bits(5) | 5'd1;
      write_reg(`SPMMIO_UNIT_MISC, `SPMMIO_MISC_SWRST, 4'hf, {27'b0, v});
      @(negedge clk);
      check_value("sw_reset_o", sw_reset_o, v);
      @(negedge clk);
      check_value("sw_reset_o", sw_reset_o, 0);

      // ~~~~~~~~~~~~~~~~~~~~
      // Keyboard
      press_key(random_bits(7), random_bits(4));
      read_check(`SPMMIO_UNIT_KBD, `SPMMIO_KBD_DATA);
      read_check(`SPMMIO_UNIT_KBD, `SPMMIO_KBD_DATA);
      press_key(random_bits(7), random_bits(4));
      press_key(random_bits(7), random_bits(4));
      read_check(`SPMMIO_UNIT_KBD, `SPMMIO_KBD_DATA);
      read_check(`SPMMIO_UNIT_KBD, `SPMMIO_KBD_DATA);
      for (int i = 1; i >= 0; i--) begin
         write_reg(`SPMMIO_UNIT_KBD, `SPMMIO_KBD_CTRL, 4'hf, i);
         @(negedge clk);
         check_value("keyboard_block_o", keyboard_block_o, block_m);
         read_check(`SPMMIO_UNIT_KBD, `SPMMIO_KBD_CTRL);
      end

      // ~~~~~~~~~~~~~~~~~~~~
      // UART loopback
      for (int i = 0; i < 4; i++) begin
         b = random_bits(8);
         write_reg(`SPMMIO_UNIT_UART, `SPMMIO_UART_TX, 4'hf, {24'b0, b});
         do bus_cycle(1'b0, reg_addr(`SPMMIO_UNIT_UART, `SPMMIO_UART_STAT), 4'hf, '0,
                      1'b0, '0, got);
         while (got[31]);
         do bus_cycle(1'b0, reg_addr(`SPMMIO_UNIT_UART, `SPMMIO_UART_STAT), 4'hf, '0,
                      1'b0, '0, got);
         while (!got[30]);
         rx_valid_m = 1'b1;
         rx_byte_m  = b;
         read_check(`SPMMIO_UNIT_UART, `SPMMIO_UART_RX);
         read_check(`SPMMIO_UNIT_UART, `SPMMIO_UART_STAT);
      end

      // Units 1, 3 and 5 are not mapped.
      for (int u = 1; u < 6; u += 2) read_check(u, random_bits(4));

      repeat (2) @(posedge clk);
      errors += u_spmmio.u_checker.fail_count;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== uart/spmmio_uart.sv ====
`timescale 1ns/10ps
`include "spmmio_params.svh"

module spmmio_uart (
   input  logic       clk,
   input  logic       rst_n_i,
   spmmio_bus_if.unit bus,
   input  logic       uart_rxd_i,
   output logic       uart_txd_o
);

   localparam int DIV = `SPMMIO_UART_DIV;
   localparam int CW  = $clog2(DIV);

   localparam logic [CW-1:0] TX_LAST = CW'(DIV - 1);
   localparam logic [CW:0]   RX_HALF = (CW+1)'(DIV/2 - 1);     // Middle of start bit.
   localparam logic [CW:0]   RX_FULL = (CW+1)'(DIV - 1);
   localparam logic [CW:0]   RX_END  = (CW+1)'(DIV + DIV/2 - 1); // Mid stop to its end.

   spmmio_pkg::uart_state_e tx_state;
   spmmio_pkg::uart_state_e rx_state;

   logic          tx_start;
   logic          tx_bit_end;
   logic [CW-1:0] tx_cnt;
   logic [2:0]    tx_bit;
   logic [0:7]    tx_shift;
   logic          txd_q;

   logic          rx_rd;
   logic          rx_step;
   logic          rxd_meta;
   logic          rxd_sync;
   logic [CW:0]   rx_cnt;
   logic [2:0]    rx_bit;
   logic [0:7]    rx_shift;
   logic [0:7]    rx_data;
   logic          rx_valid;

   assign tx_start = bus.cs && bus.we && bus.adr == `SPMMIO_UART_TX && bus.sel[3]
                     && tx_state == spmmio_pkg::IDLE; // Ignored while busy.
   assign rx_rd    = bus.cs && !bus.we && bus.adr == `SPMMIO_UART_RX;

   // ~~~~~~~~~~~~~~~~~~~~
   // Transmitter
   assign tx_bit_end = tx_cnt == TX_LAST;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tx_state <= spmmio_pkg::IDLE;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         txd_q    <= 1'b1;
      end else begin
         tx_cnt <= (tx_state == spmmio_pkg::IDLE || tx_bit_end) ? '0 : tx_cnt + 1'b1;
         case (tx_state)
            spmmio_pkg::IDLE: begin
               if (tx_start) begin
                  tx_state <= spmmio_pkg::START;
                  txd_q    <= 1'b0;
               end
            end
            spmmio_pkg::START: begin
               if (tx_bit_end) begin
                  tx_state <= spmmio_pkg::DATA;
                  tx_bit   <= '0;
                  txd_q    <= tx_shift[7]; // LSB first.
               end
            end
            spmmio_pkg::DATA: begin
               if (tx_bit_end) begin
                  tx_bit <= tx_bit + 1'b1;
                  if (tx_bit == 3'd7) begin
                     tx_state <= spmmio_pkg::STOP;
                     txd_q    <= 1'b1;
                  end else begin
                     txd_q <= tx_shift[6];
                  end
               end
            end
            default: begin
               if (tx_bit_end) begin
                  tx_state <= spmmio_pkg::IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (tx_start) begin
         tx_shift <= bus.d[24:31];
      end else if (tx_state == spmmio_pkg::DATA && tx_bit_end) begin
         tx_shift <= {1'b0, tx_shift[0:6]};
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Receiver
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= uart_rxd_i;
         rxd_sync <= rxd_meta;
      end
   end

   always_comb begin
      case (rx_state)
         spmmio_pkg::START: rx_step = rx_cnt == RX_HALF;
         spmmio_pkg::DATA:  rx_step = rx_cnt == RX_FULL;
         spmmio_pkg::STOP:  rx_step = rx_cnt == RX_END;
         default:           rx_step = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rx_state <= spmmio_pkg::IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_cnt <= (rx_state == spmmio_pkg::IDLE || rx_step) ? '0 : rx_cnt + 1'b1;
         if (rx_state == spmmio_pkg::STOP && rx_step) begin
            rx_valid <= 1'b1;
         end else if (rx_rd) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            spmmio_pkg::IDLE: begin
               if (!rxd_sync) begin
                  rx_state <= spmmio_pkg::START;
               end
            end
            spmmio_pkg::START: begin
               if (rx_step) begin
                  rx_bit   <= '0;
                  // A high line at mid start bit was a glitch.
                  rx_state <= rxd_sync ? spmmio_pkg::IDLE : spmmio_pkg::DATA;
               end
            end
            spmmio_pkg::DATA: begin
               if (rx_step) begin
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= spmmio_pkg::STOP;
                  end
               end
            end
            default: begin
               if (rx_step) begin
                  rx_state <= spmmio_pkg::IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_state == spmmio_pkg::DATA && rx_step) begin
         rx_shift <= {rxd_sync, rx_shift[0:6]};
      end
      if (rx_state == spmmio_pkg::STOP && rx_step) begin
         rx_data <= rx_shift;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Read data
   always_comb begin
      bus.q = '0;
      case (bus.adr)
         `SPMMIO_UART_STAT: begin
            bus.q[31] = tx_state != spmmio_pkg::IDLE; // Busy.
            bus.q[30] = rx_valid;
         end
         `SPMMIO_UART_RX: bus.q[24:31] = rx_data;
         default: ;
      endcase
   end

   assign uart_txd_o = txd_q;

endmodule
